/* hw/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

   // Word and address geometry
   localparam int addr_width = 32;
   localparam int data_width = 32;
   localparam int num_bytes = 4;

   // A block is 16 bytes, four words
   localparam int block_width = 4;
   localparam int words_per_block = 4;
   localparam int word_sel_width = 2;

   // 16 sets, tag is everything above the set index
   localparam int set_width = 4;
   localparam int num_sets = 16;
   localparam int tag_width = 24;
   localparam int num_ways = 2;

   // Special-register bus
   localparam int spr_addr_width = 16;
   localparam logic [15:0] spr_dcbfr_addr = 16'h1802;
   localparam logic [15:0] spr_dcbir_addr = 16'h1803;

   // One way of a tag entry
   typedef struct packed {
      logic valid;
      logic [tag_width-1:0] tag;
   } tag_way_t;

   // Full tag entry of a set
   // lru names the way to replace next
   typedef struct packed {
      logic lru;
      tag_way_t [num_ways-1:0] way;
   } tag_entry_t;

endpackage

`default_nettype wire

/* hw/dcache_dpram.sv */
`timescale 1ns/10ps
`default_nettype none

module dcache_dpram #(
   parameter type payload_t = logic,
   parameter int depth = 16
) (
   input  wire logic                     clk,
   input  wire logic [$clog2(depth)-1:0] raddr_i,
   input  wire logic [$clog2(depth)-1:0] waddr_i,
   input  wire logic                     we_i,
   input  wire payload_t                 din_i,
   output payload_t                      dout_o
);

   // Storage array, contents undefined after reset
   payload_t mem [depth];

   // Write port
   always_ff @(posedge clk) begin
      if (we_i) begin
         mem[waddr_i] <= din_i;
      end
   end

   // Registered read, a same-cycle write returns the old word
   always_ff @(posedge clk) begin
      dout_o <= mem[raddr_i];
   end

endmodule

`default_nettype wire

/* hw/dcache_tag_store.sv */
`timescale 1ns/10ps
`default_nettype none

module dcache_tag_store (
   input  wire logic                                clk,
   input  wire logic [dcache_pkg::set_width-1:0]    rindex_i,
   input  wire logic [dcache_pkg::set_width-1:0]    windex_i,
   input  wire logic [dcache_pkg::tag_width-1:0]    tag_i,
   input  wire logic                                we_i,
   input  wire logic                                fill_i,
   input  wire logic                                clear_i,
   output logic      [dcache_pkg::num_ways-1:0]     hit_way_o,
   output logic      [dcache_pkg::num_ways-1:0]     victim_way_o
);

   // Entry of the set read last cycle
   dcache_pkg::tag_entry_t entry;
   // Entry written back on we_i
   dcache_pkg::tag_entry_t next_entry;

   dcache_dpram #(
      .payload_t (dcache_pkg::tag_entry_t),
      .depth     (dcache_pkg::num_sets)
   ) i_tag_ram (
      .clk     (clk),
      .raddr_i (rindex_i),
      .waddr_i (windex_i),
      .we_i    (we_i),
      .din_i   (next_entry),
      .dout_o  (entry)
   );

   // Hit per way: valid and tag equal
   always_comb begin
      for (int w = 0; w < dcache_pkg::num_ways; w++) begin
         hit_way_o[w] = entry.way[w].valid && (entry.way[w].tag == tag_i);
      end
   end

   // One-hot victim from the LRU bit
   always_comb begin
      victim_way_o = '0;
      victim_way_o[entry.lru] = 1'b1;
   end

   // Next entry for the write port
   always_comb begin
      next_entry = entry;
      if (clear_i) begin
         // Invalidate both ways, LRU back to way 0
         next_entry = '0;
      end else if (fill_i) begin
         // Refilled block goes into the LRU way
         next_entry.way[entry.lru].valid = 1'b1;
         next_entry.way[entry.lru].tag = tag_i;
         next_entry.lru = ~entry.lru;
      end else if (|hit_way_o) begin
         // Point away from the way just used
         next_entry.lru = hit_way_o[0];
      end
   end

endmodule

`default_nettype wire

/* hw/dcache_data_store.sv */
`timescale 1ns/10ps
`default_nettype none

module dcache_data_store (
   input  wire logic                                  clk,
   input  wire logic [dcache_pkg::set_width+dcache_pkg::word_sel_width-1:0] raddr_i,
   input  wire logic [dcache_pkg::set_width+dcache_pkg::word_sel_width-1:0] waddr_i,
   input  wire logic [dcache_pkg::num_ways-1:0]       way_we_i,
   input  wire logic                                  refill_i,
   input  wire logic [dcache_pkg::data_width-1:0]     refill_dat_i,
   input  wire logic [dcache_pkg::data_width-1:0]     cpu_dat_i,
   input  wire logic [dcache_pkg::num_bytes-1:0]      bsel_i,
   input  wire logic [dcache_pkg::num_ways-1:0]       hit_way_i,
   output logic      [dcache_pkg::data_width-1:0]     dat_o
);

   // Read word of each way
   logic [dcache_pkg::data_width-1:0] way_dout [dcache_pkg::num_ways];
   // CPU data merged into the current word
   logic [dcache_pkg::data_width-1:0] merged;
   // Shared write data of both ways
   logic [dcache_pkg::data_width-1:0] way_din;

   for (genvar w = 0; w < dcache_pkg::num_ways; w++) begin : g_way
      dcache_dpram #(
         .payload_t (logic [dcache_pkg::data_width-1:0]),
         .depth     (dcache_pkg::num_sets * dcache_pkg::words_per_block)
      ) i_way_ram (
         .clk     (clk),
         .raddr_i (raddr_i),
         .waddr_i (waddr_i),
         .we_i    (way_we_i[w]),
         .din_i   (way_din),
         .dout_o  (way_dout[w])
      );
   end

   // Hitting way onto the CPU port, way 0 when nothing hits
   always_comb begin
      dat_o = way_dout[0];
      for (int w = 1; w < dcache_pkg::num_ways; w++) begin
         if (hit_way_i[w]) begin
            dat_o = way_dout[w];
         end
      end
   end

   // Byte lanes with bsel set take the CPU data
   always_comb begin
      for (int b = 0; b < dcache_pkg::num_bytes; b++) begin
         merged[8*b +: 8] = bsel_i[b] ? cpu_dat_i[8*b +: 8] : dat_o[8*b +: 8];
      end
   end

   // Refill words are written whole
   assign way_din = refill_i ? refill_dat_i : merged;

endmodule

`default_nettype wire

/* hw/dcache_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module dcache_ctrl (
   input  wire logic                                     clk,
   input  wire logic                                     rst,
   // CPU request
   input  wire logic                                     req_i,
   input  wire logic                                     we_i,
   input  wire logic [dcache_pkg::addr_width-1:0]        adr_i,
   // Special-register bus
   input  wire logic                                     spr_stb_i,
   input  wire logic                                     spr_we_i,
   input  wire logic [dcache_pkg::spr_addr_width-1:0]    spr_addr_i,
   input  wire logic [dcache_pkg::data_width-1:0]        spr_dat_i,
   // Memory refill
   input  wire logic                                     mem_valid_i,
   // Tag store results
   input  wire logic [dcache_pkg::num_ways-1:0]          hit_way_i,
   input  wire logic [dcache_pkg::num_ways-1:0]          victim_way_i,
   output logic                                          ack_o,
   output logic                                          refill_req_o,
   output logic      [dcache_pkg::addr_width-1:0]        refill_adr_o,
   output logic                                          spr_ack_o,
   // Tag store control
   output logic      [dcache_pkg::set_width-1:0]         tag_rindex_o,
   output logic      [dcache_pkg::set_width-1:0]         tag_windex_o,
   output logic                                          tag_we_o,
   output logic                                          fill_o,
   output logic                                          clear_o,
   // Data store control
   output logic      [dcache_pkg::num_ways-1:0]          way_we_o,
   output logic [dcache_pkg::set_width+dcache_pkg::word_sel_width-1:0] data_raddr_o,
   output logic [dcache_pkg::set_width+dcache_pkg::word_sel_width-1:0] data_waddr_o,
   output logic                                          refill_o
);

   typedef enum logic [2:0] {
      st_clear,
      st_idle,
      st_read,
      st_write,
      st_refill,
      st_reread,
      st_inval
   } state_t;

   state_t state;

   // Set walked by the post-reset clear
   logic [dcache_pkg::set_width-1:0]      clr_idx;
   // Next word of the block being refilled
   logic [dcache_pkg::word_sel_width-1:0] word_cnt;
   // Way chosen for the running refill
   logic [dcache_pkg::num_ways-1:0]       victim_q;

   // Address fields of the CPU request
   logic [dcache_pkg::set_width-1:0] adr_set;
   logic [dcache_pkg::set_width-1:0] spr_set;
   logic                             hit;
   logic                             last_word;
   logic                             inval_req;

   assign adr_set = adr_i[dcache_pkg::block_width +: dcache_pkg::set_width];
   assign spr_set = spr_dat_i[dcache_pkg::block_width +: dcache_pkg::set_width];
   assign hit = |hit_way_i;
   assign last_word = (word_cnt == dcache_pkg::word_sel_width'(dcache_pkg::words_per_block - 1));

   // Block flush and block invalidate both clear the set
   assign inval_req = spr_we_i && ((spr_addr_i == dcache_pkg::spr_dcbfr_addr) ||
                                   (spr_addr_i == dcache_pkg::spr_dcbir_addr));

   // Both RAMs always read at the request address
   assign tag_rindex_o = adr_set;
   assign data_raddr_o = adr_i[2 +: dcache_pkg::set_width + dcache_pkg::word_sel_width];

   // Refill request stays up for the whole block
   assign refill_req_o = (state == st_refill);
   assign refill_adr_o = {adr_i[dcache_pkg::addr_width-1:dcache_pkg::block_width],
                          {dcache_pkg::block_width{1'b0}}};

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= st_clear;
         clr_idx <= '0;
         word_cnt <= '0;
         ack_o <= 1'b0;
         spr_ack_o <= 1'b0;
      end else begin
         // Acknowledges are single-cycle pulses
         ack_o <= 1'b0;
         spr_ack_o <= 1'b0;
         case (state)
            st_clear: begin
               clr_idx <= clr_idx + 1'b1;
               if (clr_idx == dcache_pkg::set_width'(dcache_pkg::num_sets - 1)) begin
                  state <= st_idle;
               end
            end
            st_idle: begin
               // Invalidate wins over a CPU request
               // A request in its ack cycle is already served
               if (spr_stb_i && !spr_ack_o) begin
                  if (inval_req) begin
                     state <= st_inval;
                  end else begin
                     spr_ack_o <= 1'b1;
                  end
               end else if (req_i && !ack_o) begin
                  state <= we_i ? st_write : st_read;
               end
            end
            st_read: begin
               if (hit) begin
                  ack_o <= 1'b1;
                  state <= st_idle;
               end else begin
                  word_cnt <= '0;
                  state <= st_refill;
               end
            end
            st_write: begin
               // No allocate on a write miss
               ack_o <= 1'b1;
               state <= st_idle;
            end
            st_refill: begin
               if (mem_valid_i) begin
                  word_cnt <= word_cnt + 1'b1;
                  if (last_word) begin
                     state <= st_reread;
                  end
               end
            end
            st_reread: begin
               // RAMs now read the refilled block
               ack_o <= 1'b1;
               state <= st_idle;
            end
            st_inval: begin
               spr_ack_o <= 1'b1;
               state <= st_idle;
            end
            default: begin
               state <= st_idle;
            end
         endcase
      end
   end

   // Victim captured when the miss is found
   always_ff @(posedge clk) begin
      if (state == st_read && !hit) begin
         victim_q <= victim_way_i;
      end
   end

   // RAM write control
   always_comb begin
      tag_we_o = 1'b0;
      fill_o = 1'b0;
      clear_o = 1'b0;
      way_we_o = '0;
      refill_o = 1'b0;
      tag_windex_o = adr_set;
      data_waddr_o = data_raddr_o;
      case (state)
         st_clear: begin
            tag_we_o = 1'b1;
            clear_o = 1'b1;
            tag_windex_o = clr_idx;
         end
         st_read: begin
            // LRU update on a hit
            tag_we_o = hit;
         end
         st_write: begin
            tag_we_o = hit;
            way_we_o = hit_way_i;
         end
         st_refill: begin
            if (mem_valid_i) begin
               refill_o = 1'b1;
               way_we_o = victim_q;
               data_waddr_o = {adr_set, word_cnt};
               // Tag and valid written with the last word
               tag_we_o = last_word;
               fill_o = last_word;
            end
         end
         st_inval: begin
            tag_we_o = 1'b1;
            clear_o = 1'b1;
            tag_windex_o = spr_set;
         end
         default: begin
         end
      endcase
   end

endmodule

`default_nettype wire

/* hw/dcache_top.sv */
`timescale 1ns/10ps
`default_nettype none

module dcache_top (
   input  wire logic                                   clk,
   input  wire logic                                   rst,
   // CPU side
   input  wire logic                                   req_i,
   input  wire logic                                   we_i,
   input  wire logic [dcache_pkg::addr_width-1:0]      adr_i,
   input  wire logic [dcache_pkg::data_width-1:0]      dat_i,
   input  wire logic [dcache_pkg::num_bytes-1:0]       bsel_i,
   output logic                                        ack_o,
   output logic      [dcache_pkg::data_width-1:0]      dat_o,
   // Memory side
   output logic                                        refill_req_o,
   output logic      [dcache_pkg::addr_width-1:0]      refill_adr_o,
   input  wire logic                                   mem_valid_i,
   input  wire logic [dcache_pkg::data_width-1:0]      mem_dat_i,
   // Special-register side
   input  wire logic                                   spr_stb_i,
   input  wire logic                                   spr_we_i,
   input  wire logic [dcache_pkg::spr_addr_width-1:0]  spr_addr_i,
   input  wire logic [dcache_pkg::data_width-1:0]      spr_dat_i,
   output logic                                        spr_ack_o
);

   // Tag store links
   logic [dcache_pkg::num_ways-1:0]  hit_way;
   logic [dcache_pkg::num_ways-1:0]  victim_way;
   logic [dcache_pkg::set_width-1:0] tag_rindex;
   logic [dcache_pkg::set_width-1:0] tag_windex;
   logic                             tag_we;
   logic                             fill;
   logic                             clear;

   // Data store links
   logic [dcache_pkg::num_ways-1:0]  way_we;
   logic [dcache_pkg::set_width+dcache_pkg::word_sel_width-1:0] data_raddr;
   logic [dcache_pkg::set_width+dcache_pkg::word_sel_width-1:0] data_waddr;
   logic                             refill;

   dcache_ctrl i_ctrl (
      .clk          (clk),
      .rst          (rst),
      .req_i        (req_i),
      .we_i         (we_i),
      .adr_i        (adr_i),
      .spr_stb_i    (spr_stb_i),
      .spr_we_i     (spr_we_i),
      .spr_addr_i   (spr_addr_i),
      .spr_dat_i    (spr_dat_i),
      .mem_valid_i  (mem_valid_i),
      .hit_way_i    (hit_way),
      .victim_way_i (victim_way),
      .ack_o        (ack_o),
      .refill_req_o (refill_req_o),
      .refill_adr_o (refill_adr_o),
      .spr_ack_o    (spr_ack_o),
      .tag_rindex_o (tag_rindex),
      .tag_windex_o (tag_windex),
      .tag_we_o     (tag_we),
      .fill_o       (fill),
      .clear_o      (clear),
      .way_we_o     (way_we),
      .data_raddr_o (data_raddr),
      .data_waddr_o (data_waddr),
      .refill_o     (refill)
   );

   // Compare tag is the top of the request address
   dcache_tag_store i_tag_store (
      .clk          (clk),
      .rindex_i     (tag_rindex),
      .windex_i     (tag_windex),
      .tag_i        (adr_i[dcache_pkg::addr_width-1 -: dcache_pkg::tag_width]),
      .we_i         (tag_we),
      .fill_i       (fill),
      .clear_i      (clear),
      .hit_way_o    (hit_way),
      .victim_way_o (victim_way)
   );

   dcache_data_store i_data_store (
      .clk          (clk),
      .raddr_i      (data_raddr),
      .waddr_i      (data_waddr),
      .way_we_i     (way_we),
      .refill_i     (refill),
      .refill_dat_i (mem_dat_i),
      .cpu_dat_i    (dat_i),
      .bsel_i       (bsel_i),
      .hit_way_i    (hit_way),
      .dat_o        (dat_o)
   );

endmodule

`default_nettype wire

/* verif/dcache_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module dcache_checker (
   input  wire logic        clk,
   input  wire logic        rst,
   // CPU port as seen at the DUT
   input  wire logic        req_i,
   input  wire logic        we_i,
   input  wire logic [31:0] adr_i,
   input  wire logic [31:0] dat_i,
   input  wire logic [3:0]  bsel_i,
   input  wire logic        ack_i,
   input  wire logic [31:0] rdata_i,
   // Refill and special-register ports
   input  wire logic        refill_req_i,
   input  wire logic [31:0] refill_adr_i,
   input  wire logic        spr_stb_i,
   input  wire logic        spr_we_i,
   input  wire logic [15:0] spr_addr_i,
   input  wire logic [31:0] spr_dat_i,
   input  wire logic        spr_ack_i,
   output int               mismatches_o,
   output int               errors_o
);

   // Memory model holding only the words written so far
   logic [31:0] model_mem [logic [29:0]];
   // Tag model per set and way
   logic        valid [dcache_pkg::num_sets][dcache_pkg::num_ways];
   logic [dcache_pkg::tag_width-1:0] tags [dcache_pkg::num_sets][dcache_pkg::num_ways];
   // Way to replace next
   logic        lru [dcache_pkg::num_sets];
   // Cycles since reset, counted up to the length of the set clear
   int          clear_cycles;
   // Request in flight
   logic        req_active;
   logic        spr_active;
   logic        refill_seen;
   logic [31:0] cur_adr;
   logic        cur_we;
   logic [31:0] cur_dat;
   logic [3:0]  cur_bsel;
   logic        cur_spr_match;
   logic [31:0] cur_spr_dat;
   logic [31:0] expected;

   function automatic logic [31:0] init_word(input logic [31:0] a);
      return (a * 32'h9e37_79b1) ^ 32'h5a5a_3c3c;
   endfunction

   function automatic logic [31:0] read_model(input logic [31:0] a);
      if (model_mem.exists(a[31:2])) begin
         return model_mem[a[31:2]];
      end
      return init_word({a[31:2], 2'b00});
   endfunction

   function automatic logic [31:0] merge_lanes(input logic [31:0] old_w,
                                               input logic [31:0] new_w,
                                               input logic [3:0] sel);
      logic [31:0] m;
      for (int b = 0; b < 4; b++) begin
         m[8*b +: 8] = sel[b] ? new_w[8*b +: 8] : old_w[8*b +: 8];
      end
      return m;
   endfunction

   function automatic logic [dcache_pkg::set_width-1:0] set_of(input logic [31:0] a);
      return a[dcache_pkg::block_width +: dcache_pkg::set_width];
   endfunction

   function automatic logic [dcache_pkg::tag_width-1:0] tag_of(input logic [31:0] a);
      return a[dcache_pkg::addr_width-1 -: dcache_pkg::tag_width];
   endfunction

   // Hit vector with bit 1 for way 1
   function automatic logic [1:0] lookup(input logic [31:0] a);
      logic [dcache_pkg::set_width-1:0] s;
      s = set_of(a);
      return {valid[s][1] && (tags[s][1] == tag_of(a)),
              valid[s][0] && (tags[s][0] == tag_of(a))};
   endfunction

   // LRU moves away from the used way
   // A read miss fills the LRU way
   task automatic touch(input logic [31:0] a, input logic allocate);
      logic [1:0] h;
      logic [dcache_pkg::set_width-1:0] s;
      logic used;
      h = lookup(a);
      s = set_of(a);
      if (h != 2'b00) begin
         used = h[1];
         lru[s] = ~used;
      end else if (allocate) begin
         used = lru[s];
         valid[s][used] = 1'b1;
         tags[s][used] = tag_of(a);
         lru[s] = ~used;
      end
   endtask

   always @(posedge clk) begin
      if (rst) begin
         for (int s = 0; s < dcache_pkg::num_sets; s++) begin
            lru[s] = 1'b0;
            for (int w = 0; w < dcache_pkg::num_ways; w++) begin
               valid[s][w] = 1'b0;
            end
         end
         clear_cycles = 0;
         req_active = 1'b0;
         spr_active = 1'b0;
         refill_seen = 1'b0;
         mismatches_o = 0;
         errors_o = 0;
      end else begin
         // Refill only for a read whose block the model lacks
         if (refill_req_i && !refill_seen) begin
            refill_seen = 1'b1;
            if (!req_active || cur_we || lookup(cur_adr) != 2'b00) begin
               $display("Error: refill requested at %h with no read miss pending", refill_adr_i);
               errors_o++;
            end else if (refill_adr_i != {cur_adr[31:4], 4'h0}) begin
               $display("MISMATCH refill_adr_o: expected %h, got %h",
                        {cur_adr[31:4], 4'h0}, refill_adr_i);
               mismatches_o++;
            end
         end
         if (ack_i) begin
            if (!req_active) begin
               $display("Error: ack_o without a pending request");
               errors_o++;
            end else if (!cur_we) begin
               expected = read_model(cur_adr);
               if (rdata_i !== expected) begin
                  $display("MISMATCH dat_o: expected %h, got %h at address %h",
                           expected, rdata_i, cur_adr);
                  mismatches_o++;
               end
               if (lookup(cur_adr) == 2'b00 && !refill_seen) begin
                  $display("Error: read miss at %h returned without a refill", cur_adr);
                  errors_o++;
               end
               touch(cur_adr, 1'b1);
            end else begin
               // Write-through without allocate on a miss
               model_mem[cur_adr[31:2]] = merge_lanes(read_model(cur_adr), cur_dat, cur_bsel);
               touch(cur_adr, 1'b0);
            end
            req_active = 1'b0;
            refill_seen = 1'b0;
         end else if (req_i && !req_active) begin
            req_active = 1'b1;
            refill_seen = 1'b0;
            cur_adr = adr_i;
            cur_we = we_i;
            cur_dat = dat_i;
            cur_bsel = bsel_i;
         end
         // Special-register strobes
         if (spr_ack_i) begin
            if (!spr_active) begin
               $display("Error: spr_ack_o without a pending strobe");
               errors_o++;
            end else if (cur_spr_match) begin
               lru[set_of(cur_spr_dat)] = 1'b0;
               valid[set_of(cur_spr_dat)][0] = 1'b0;
               valid[set_of(cur_spr_dat)][1] = 1'b0;
            end
            spr_active = 1'b0;
         end else if (spr_stb_i && !spr_active) begin
            spr_active = 1'b1;
            cur_spr_dat = spr_dat_i;
            cur_spr_match = spr_we_i && (spr_addr_i == dcache_pkg::spr_dcbfr_addr ||
                                         spr_addr_i == dcache_pkg::spr_dcbir_addr);
         end
      end
      // Outputs stay low through reset and the clear of all sets after it
      if (clear_cycles < dcache_pkg::num_sets) begin
         if (ack_i === 1'b1 || refill_req_i === 1'b1 || spr_ack_i === 1'b1) begin
            $display("Error: ack_o, refill_req_o or spr_ack_o high before the clear ended");
            errors_o++;
         end
         if (!rst) begin
            clear_cycles++;
         end
      end
   end

endmodule

`default_nettype wire

/* verif/tb_dcache.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_dcache;

   // Directed operations, random mix and the cycle budget
   localparam int num_directed = 17;
   localparam int num_random = 300;
   localparam int timeout_limit = (num_directed + num_random) * 40 + 200;

   logic clk = 1'b0;
   logic rst = 1'b1;
   // CPU side
   logic        req;
   logic        we;
   logic [31:0] adr;
   logic [31:0] wdat;
   logic [3:0]  bsel;
   logic        ack;
   logic [31:0] rdat;
   // Memory side
   logic        refill_req;
   logic [31:0] refill_adr;
   logic        mem_valid = 1'b0;
   logic [31:0] mem_dat = 32'd0;
   // Special-register side
   logic        spr_stb;
   logic        spr_we;
   logic [15:0] spr_addr;
   logic [31:0] spr_dat;
   logic        spr_ack;

   int          mismatches;
   int          errors;
   int          cycles = 0;
   integer      seed;
   // Responder state; gap_bits is redrawn for every CPU access
   logic [31:0] gap_bits;
   logic [4:0]  gap_pos = 5'd0;
   logic [2:0]  refill_cnt = 3'd0;
   // Backing memory, only written words are stored
   logic [31:0] mem_words [logic [29:0]];

   always #4 clk = ~clk;

   // Fill value of a memory word, odd multiplier keeps every address bit
   function automatic logic [31:0] init_word(input logic [31:0] a);
      return (a * 32'h9e37_79b1) ^ 32'h5a5a_3c3c;
   endfunction

   function automatic logic [31:0] read_mem(input logic [31:0] a);
      if (mem_words.exists(a[31:2])) begin
         return mem_words[a[31:2]];
      end
      return init_word({a[31:2], 2'b00});
   endfunction

   // Byte lanes with sel set come from new_w
   function automatic logic [31:0] merge_lanes(input logic [31:0] old_w,
                                               input logic [31:0] new_w,
                                               input logic [3:0] sel);
      logic [31:0] m;
      for (int b = 0; b < 4; b++) begin
         m[8*b +: 8] = sel[b] ? new_w[8*b +: 8] : old_w[8*b +: 8];
      end
      return m;
   endfunction

   // Four tag values per set so that the two ways conflict
   function automatic logic [31:0] make_adr(input logic [1:0] tag_sel, input logic [3:0] set,
                                            input logic [1:0] word);
      logic [23:0] t;
      t = 24'h5a_c300 ^ ({22'd0, tag_sel} * 24'h0b_1f27);
      return {t, set, word, 2'b00};
   endfunction

   // CPU access held until ack, a write also lands in memory
   task automatic cpu_access(input logic w, input logic [31:0] a, input logic [31:0] d,
                             input logic [3:0] b);
      gap_bits <= $random(seed) | $random(seed);
      req <= 1'b1;
      we <= w;
      adr <= a;
      wdat <= d;
      bsel <= b;
      @(posedge clk);
      while (!ack) begin
         @(posedge clk);
      end
      req <= 1'b0;
      if (w) begin
         mem_words[a[31:2]] = merge_lanes(read_mem(a), d, b);
      end
      // At least one idle cycle between requests
      @(posedge clk);
   endtask

   task automatic spr_access(input logic w, input logic [15:0] a, input logic [31:0] d);
      spr_stb <= 1'b1;
      spr_we <= w;
      spr_addr <= a;
      spr_dat <= d;
      @(posedge clk);
      while (!spr_ack) begin
         @(posedge clk);
      end
      spr_stb <= 1'b0;
      @(posedge clk);
   endtask

   dcache_top i_dcache_top (
      .clk          (clk),
      .rst          (rst),
      .req_i        (req),
      .we_i         (we),
      .adr_i        (adr),
      .dat_i        (wdat),
      .bsel_i       (bsel),
      .ack_o        (ack),
      .dat_o        (rdat),
      .refill_req_o (refill_req),
      .refill_adr_o (refill_adr),
      .mem_valid_i  (mem_valid),
      .mem_dat_i    (mem_dat),
      .spr_stb_i    (spr_stb),
      .spr_we_i     (spr_we),
      .spr_addr_i   (spr_addr),
      .spr_dat_i    (spr_dat),
      .spr_ack_o    (spr_ack)
   );

   dcache_checker i_dcache_checker (
      .clk          (clk),
      .rst          (rst),
      .req_i        (req),
      .we_i         (we),
      .adr_i        (adr),
      .dat_i        (wdat),
      .bsel_i       (bsel),
      .ack_i        (ack),
      .rdata_i      (rdat),
      .refill_req_i (refill_req),
      .refill_adr_i (refill_adr),
      .spr_stb_i    (spr_stb),
      .spr_we_i     (spr_we),
      .spr_addr_i   (spr_addr),
      .spr_dat_i    (spr_dat),
      .spr_ack_i    (spr_ack),
      .mismatches_o (mismatches),
      .errors_o     (errors)
   );

   // Memory responder, words in ascending order with random gaps
   always @(posedge clk) begin
      if (rst || !refill_req) begin
         mem_valid <= 1'b0;
         refill_cnt <= 3'd0;
         gap_pos <= 5'd0;
      end else begin
         gap_pos <= gap_pos + 5'd1;
         if (refill_cnt < 3'd4 && gap_bits[gap_pos]) begin
            mem_valid <= 1'b1;
            mem_dat <= read_mem(refill_adr + {27'd0, refill_cnt, 2'b00});
            refill_cnt <= refill_cnt + 3'd1;
         end else begin
            mem_valid <= 1'b0;
         end
      end
   end

   // Run limit
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= timeout_limit) begin
         $display("Timeout: run did not finish within %0d cycles", timeout_limit);
         $display("STATUS: FAIL");
         $finish;
      end
   end

   initial begin
      logic [31:0] r;
      logic [31:0] a;
      logic [31:0] d;
      logic [31:0] blk_a;
      logic [31:0] blk_b;
      logic [31:0] blk_c;
      logic [31:0] blk_d;
      seed = 32'h95a4_e657;
      gap_bits = 32'hffff_ffff;
      req = 1'b0;
      we = 1'b0;
      adr = 32'd0;
      wdat = 32'd0;
      bsel = 4'd0;
      spr_stb = 1'b0;
      spr_we = 1'b0;
      spr_addr = 16'd0;
      spr_dat = 32'd0;
      repeat (10) @(posedge clk);
      rst <= 1'b0;
      // Three blocks of set 5 and one of set 6
      blk_a = make_adr(2'd0, 4'd5, 2'd0);
      blk_b = make_adr(2'd1, 4'd5, 2'd1);
      blk_c = make_adr(2'd2, 4'd5, 2'd2);
      blk_d = make_adr(2'd0, 4'd6, 2'd3);
      // LRU: A and B fill, A reused, C must evict B
      cpu_access(1'b0, blk_a, 32'd0, 4'd0);
      cpu_access(1'b0, blk_b, 32'd0, 4'd0);
      cpu_access(1'b0, blk_a, 32'd0, 4'd0);
      cpu_access(1'b0, blk_c, 32'd0, 4'd0);
      cpu_access(1'b0, blk_a, 32'd0, 4'd0);
      cpu_access(1'b0, blk_b, 32'd0, 4'd0);
      // Byte-select write hit, then read it back
      cpu_access(1'b1, blk_b, 32'hdead_beef, 4'b0101);
      cpu_access(1'b0, blk_b, 32'd0, 4'd0);
      // Block invalidate of set 5 leaves set 6 alone
      cpu_access(1'b0, blk_d, 32'd0, 4'd0);
      spr_access(1'b1, dcache_pkg::spr_dcbir_addr, blk_a);
      cpu_access(1'b0, blk_b, 32'd0, 4'd0);
      cpu_access(1'b0, blk_c, 32'd0, 4'd0);
      cpu_access(1'b0, blk_d, 32'd0, 4'd0);
      // Other address has no effect, block flush does
      spr_access(1'b1, 16'h1801, blk_d);
      cpu_access(1'b0, blk_d, 32'd0, 4'd0);
      spr_access(1'b1, dcache_pkg::spr_dcbfr_addr, blk_d);
      cpu_access(1'b0, blk_d, 32'd0, 4'd0);
      // Random mix of reads, writes and special-register strobes
      for (int i = 0; i < num_random; i++) begin
         r = $random(seed);
         d = $random(seed);
         a = make_adr(r[1:0], r[5:2], r[7:6]);
         case (r[10:8])
            3'd0: spr_access(r[11], 16'h1800 + {14'd0, r[13:12]}, a);
            3'd1, 3'd2: cpu_access(1'b1, a, d, r[15:12]);
            default: cpu_access(1'b0, a, 32'd0, 4'd0);
         endcase
      end
      repeat (4) @(posedge clk);
      $display("Checks done: %0d mismatches, %0d other errors", mismatches, errors);
      if (mismatches == 0 && errors == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* sim.f */
hw/dcache_pkg.sv
hw/dcache_dpram.sv
hw/dcache_tag_store.sv
hw/dcache_data_store.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
verif/dcache_checker.sv
verif/tb_dcache.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the data cache testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --timescale 1ns/10ps -j 0 \
   --top-module tb_dcache -Mdir "$build_dir" -o sim_dcache -f sim.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$build_dir/sim_dcache" > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi

if grep -q "^STATUS: PASS$" "$log_file"; then
   echo "Simulation passed, log in $log_file"
   exit 0
else
   echo "Simulation failed, log in $log_file"
   exit 1
fi
